// File: Bender.yml
package:
  name: rv32_bus

sources:
  - bus_pkg.sv
  - bus_arbiter_fsm.sv
  - bus_addr_router.sv
  - bus_clint_timer.sv
  - bus_serial_tx.sv
  - bus_top.sv
  - target: simulation
    files:
      - bus_assertions.sv
      - tb_bus.sv

// File: bus_addr_router.sv
module bus_addr_router
  import bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  req_t     req_i,
  input  logic     busy_i,
  input  logic     issue_i,
  output logic     done_o,
  output word_t    rdata_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     timer_rd_hi_o,
  input  word_t    timer_word_i,
  output logic     serial_we_o
);

  logic hit_serial;
  logic hit_rtc_lo;
  logic hit_rtc_hi;
  logic hit_periph;
  logic mem_launch;
  logic mem_valid;
  logic mem_pend_q;
  logic mem_busy_q;
  logic mem_rsp_seen;
  logic periph_done_q;
  logic timer_rd_q;

  // address map, looked at only in the issue cycle
  assign hit_serial = (req_i.addr == SERIAL_ADDR);
  assign hit_rtc_lo = (req_i.addr == RTC_ADDR);
  assign hit_rtc_hi = (req_i.addr == RTC_ADDR_UP);
  assign hit_periph = hit_serial | hit_rtc_lo | hit_rtc_hi;
  assign mem_launch = issue_i & ~hit_periph;

  // held until memory takes it
  assign mem_valid = mem_launch | mem_pend_q;

  always_comb
  begin
    mem_req_o.valid = mem_valid;
    mem_req_o.addr  = req_i.addr;
    mem_req_o.wdata = req_i.wdata;
    mem_req_o.wstrb = req_i.wstrb;
    mem_req_o.we    = req_i.we;
  end

  assign mem_rsp_seen = mem_busy_q & (mem_rsp_i.rvalid | mem_rsp_i.bvalid);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_pend_q    <= 1'b0;
      mem_busy_q    <= 1'b0;
      periph_done_q <= 1'b0;
      timer_rd_q    <= 1'b0;
    end
    else
    begin
      mem_pend_q <= mem_valid & ~mem_rsp_i.ready;
      if (mem_launch)
      begin
        mem_busy_q <= 1'b1;
      end
      else if (mem_rsp_seen)
      begin
        mem_busy_q <= 1'b0;
      end
      // peripherals always answer one cycle later
      periph_done_q <= issue_i & hit_periph;
      timer_rd_q    <= issue_i & (hit_rtc_lo | hit_rtc_hi) & ~req_i.we;
    end
  end

  assign timer_rd_hi_o = hit_rtc_hi;
  assign serial_we_o   = issue_i & hit_serial & req_i.we;
  assign done_o        = busy_i & (periph_done_q | mem_rsp_seen);

  // serial reads, timer writes and memory writes return zero
  always_comb
  begin
    if (timer_rd_q)
    begin
      rdata_o = timer_word_i;
    end
    else if (mem_rsp_seen & mem_rsp_i.rvalid)
    begin
      rdata_o = mem_rsp_i.rdata;
    end
    else
    begin
      rdata_o = '0;
    end
  end

endmodule

// File: bus_arbiter_fsm.sv
module bus_arbiter_fsm
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ifu_valid_i,
  input  logic       lsu_valid_i,
  input  logic       done_i,
  output arb_state_e state_o,
  output logic       sel_lsu_o,
  output logic       issue_o
);

  arb_state_e state_q;
  arb_state_e state_d;
  logic       grant;
  logic       issue_q;

  // lsu wins when both ask in the same cycle
  always_comb
  begin
    state_d = state_q;
    grant   = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (lsu_valid_i)
        begin
          state_d = LSU_BUSY;
          grant   = 1'b1;
        end
        else if (ifu_valid_i)
        begin
          state_d = IFU_BUSY;
          grant   = 1'b1;
        end
      end
      IFU_BUSY, LSU_BUSY:
      begin
        // one transaction per grant, back to idle on completion
        if (done_i)
        begin
          state_d = IDLE;
        end
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
      issue_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // high only in the first busy cycle
      issue_q <= grant;
    end
  end

  assign state_o   = state_q;
  assign sel_lsu_o = (state_q == LSU_BUSY);
  assign issue_o   = issue_q;

endmodule

// File: bus_assertions.sv
module bus_assertions
  import bus_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     ifu_rvalid_i,
  input logic     lsu_rvalid_i,
  input logic     lsu_wready_i,
  input mem_req_t mem_req_i,
  input mem_rsp_t mem_rsp_i
);

  int fail_count = 0;

  // only the grant holder sees a completion
  one_owner: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid_i && (lsu_rvalid_i || lsu_wready_i)))
  else
  begin
    $error("completion raised for both requesters");
    fail_count++;
  end

  // stalled request held unchanged
  req_held: assert property (@(posedge clk) disable iff (rst)
    (mem_req_i.valid && !mem_rsp_i.ready) |=> $stable(mem_req_i))
  else
  begin
    $error("memory request changed while stalled");
    fail_count++;
  end

  single_pulse: assert property (@(posedge clk) disable iff (rst)
    (ifu_rvalid_i || lsu_rvalid_i || lsu_wready_i)
      |=> !(ifu_rvalid_i || lsu_rvalid_i || lsu_wready_i))
  else
  begin
    $error("completion pulse longer than one cycle");
    fail_count++;
  end

endmodule

bind bus_top bus_assertions u_assertions (
  .clk          (clk),
  .rst          (rst),
  .ifu_rvalid_i (ifu_rvalid_o),
  .lsu_rvalid_i (lsu_rvalid_o),
  .lsu_wready_i (lsu_wready_o),
  .mem_req_i    (mem_req_o),
  .mem_rsp_i    (mem_rsp_i)
);

// File: bus_clint_timer.sv
module bus_clint_timer
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  rd_hi_i,
  output word_t word_o
);

  mtime_t mtime_q;
  word_t  word_q;
  word_t  sel_word;

  // pick the half asked for in this cycle
  always_comb
  begin
    if (rd_hi_i)
    begin
      sel_word = mtime_q[63:32];
    end
    else
    begin
      sel_word = mtime_q[31:0];
    end
  end

  // free running, nothing stalls it
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q <= '0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // registered read, lines up with the peripheral done pulse
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      word_q <= '0;
    end
    else
    begin
      word_q <= sel_word;
    end
  end

  assign word_o = word_q;

endmodule

// File: bus_input.txt
// columns: kind addr wdata wstrb expected, all hex
// kind 1 fetch, 2 load, 3 store, 4 load paired with a fetch of the wdata column address
2 a000004c 00000000 0 00000000
1 00000100 00000000 0 fffffeff
2 00000104 00000000 0 fffffefb
3 00000200 11223344 f 00000000
2 00000200 00000000 0 11223344
3 00000200 aabbccdd 5 00000000
2 00000200 00000000 0 11bb33dd
1 00000200 00000000 0 11bb33dd
3 00000300 cafe0055 a 00000000
2 00000300 00000000 0 caff00ff
3 a00003f8 00000048 1 00000048
3 a00003f8 12345669 f 00000069
2 a0000048 00000000 0 00000000
2 a0000048 00000000 0 00000000
1 a0000048 00000000 0 00000000
4 00000200 00000400 0 11bb33dd
4 00000304 00000100 0 fffffcfb
3 00000104 deadbeef 3 00000000
2 00000104 00000000 0 ffffbeef
2 a00003f8 00000000 0 00000000
3 a0000048 00000007 f 00000000

// File: bus_pkg.sv
package bus_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [7:0]  byte_t;
  typedef logic [63:0] mtime_t;

  // request of the requester that holds the grant
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  we;
  } req_t;

  // single-beat request to the memory system
  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  we;
  } mem_req_t;

  // ready accepts the request; rvalid or bvalid ends it later
  typedef struct packed {
    logic  ready;
    logic  rvalid;
    logic  bvalid;
    word_t rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    IFU_BUSY,
    LSU_BUSY
  } arb_state_e;

  // fixed peripheral addresses
  localparam addr_t SERIAL_ADDR = 32'ha000_03f8;
  localparam addr_t RTC_ADDR    = 32'ha000_0048;
  localparam addr_t RTC_ADDR_UP = RTC_ADDR + 32'd4;

endpackage

// File: bus_serial_tx.sv
module bus_serial_tx
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  we_i,
  input  word_t wdata_i,
  output byte_t char_o,
  output logic  valid_o
);

  byte_t char_q;
  logic  valid_q;

  // character from the low byte lane
  always_ff @(posedge clk)
  begin
    if (we_i)
    begin
      char_q <= wdata_i[7:0];
    end
  end

  // one pulse per accepted write
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= we_i;
    end
  end

  assign char_o  = char_q;
  assign valid_o = valid_q;

endmodule

// File: bus_top.sv
module bus_top
  import bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     ifu_arvalid_i,
  input  addr_t    ifu_araddr_i,
  output word_t    ifu_rdata_o,
  output logic     ifu_rvalid_o,
  input  logic     lsu_valid_i,
  input  logic     lsu_we_i,
  input  addr_t    lsu_addr_i,
  input  word_t    lsu_wdata_i,
  input  strb_t    lsu_wstrb_i,
  output word_t    lsu_rdata_o,
  output logic     lsu_rvalid_o,
  output logic     lsu_wready_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output byte_t    serial_char_o,
  output logic     serial_valid_o
);

  arb_state_e state;
  logic       sel_lsu;
  logic       issue;
  logic       done;
  logic       ifu_owns;
  word_t      rdata;
  req_t       req;
  logic       timer_rd_hi;
  word_t      timer_word;
  logic       serial_we;

  bus_arbiter_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .ifu_valid_i (ifu_arvalid_i),
    .lsu_valid_i (lsu_valid_i),
    .done_i      (done),
    .state_o     (state),
    .sel_lsu_o   (sel_lsu),
    .issue_o     (issue)
  );

  // fetch is read only, so no data or byte enables
  always_comb
  begin
    if (sel_lsu)
    begin
      req.addr  = lsu_addr_i;
      req.wdata = lsu_wdata_i;
      req.wstrb = lsu_wstrb_i;
      req.we    = lsu_we_i;
    end
    else
    begin
      req.addr  = ifu_araddr_i;
      req.wdata = '0;
      req.wstrb = '0;
      req.we    = 1'b0;
    end
  end

  bus_addr_router u_router (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req),
    .busy_i        (state != IDLE),
    .issue_i       (issue),
    .done_o        (done),
    .rdata_o       (rdata),
    .mem_req_o     (mem_req_o),
    .mem_rsp_i     (mem_rsp_i),
    .timer_rd_hi_o (timer_rd_hi),
    .timer_word_i  (timer_word),
    .serial_we_o   (serial_we)
  );

  bus_clint_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .rd_hi_i (timer_rd_hi),
    .word_o  (timer_word)
  );

  bus_serial_tx u_serial (
    .clk     (clk),
    .rst     (rst),
    .we_i    (serial_we),
    .wdata_i (req.wdata),
    .char_o  (serial_char_o),
    .valid_o (serial_valid_o)
  );

  // completion goes back only to the grant holder
  assign ifu_owns     = (state == IFU_BUSY);
  assign ifu_rvalid_o = done & ifu_owns;
  assign lsu_rvalid_o = done & sel_lsu & ~lsu_we_i;
  assign lsu_wready_o = done & sel_lsu & lsu_we_i;
  assign ifu_rdata_o  = ifu_owns ? rdata : '0;
  assign lsu_rdata_o  = sel_lsu ? rdata : '0;

endmodule

// File: filelist.f
bus_pkg.sv
bus_arbiter_fsm.sv
bus_addr_router.sv
bus_clint_timer.sv
bus_serial_tx.sv
bus_top.sv
bus_assertions.sv
tb_bus.sv

// File: tb_bus.sv
module tb_bus
  import bus_pkg::*;
();

  logic     clk = 1'b0;
  logic     rst;
  logic     ifu_arvalid;
  addr_t    ifu_araddr;
  word_t    ifu_rdata;
  logic     ifu_rvalid;
  logic     lsu_valid;
  logic     lsu_we;
  addr_t    lsu_addr;
  word_t    lsu_wdata;
  strb_t    lsu_wstrb;
  word_t    lsu_rdata;
  logic     lsu_rvalid;
  logic     lsu_wready;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  byte_t    serial_char;
  logic     serial_valid;

  // five hex columns per data line, a zero kind ends the list
  word_t    vec [0:159];
  word_t    mem_model [logic [29:0]];
  req_t     mem_cur;
  mem_rsp_t rsp_next;
  logic     mem_busy = 1'b0;
  int       mem_reqs = 0;
  int       stall_left = 0;
  int       lat_left = 0;
  int       serial_count = 0;
  byte_t    last_char = '0;
  int       cycles = 0;
  int       cycle_limit = 100000;
  int       checks = 0;
  int       errors = 0;

  bus_top dut (
    .clk            (clk),
    .rst            (rst),
    .ifu_arvalid_i  (ifu_arvalid),
    .ifu_araddr_i   (ifu_araddr),
    .ifu_rdata_o    (ifu_rdata),
    .ifu_rvalid_o   (ifu_rvalid),
    .lsu_valid_i    (lsu_valid),
    .lsu_we_i       (lsu_we),
    .lsu_addr_i     (lsu_addr),
    .lsu_wdata_i    (lsu_wdata),
    .lsu_wstrb_i    (lsu_wstrb),
    .lsu_rdata_o    (lsu_rdata),
    .lsu_rvalid_o   (lsu_rvalid),
    .lsu_wready_o   (lsu_wready),
    .mem_req_o      (mem_req),
    .mem_rsp_i      (mem_rsp),
    .serial_char_o  (serial_char),
    .serial_valid_o (serial_valid)
  );

  always #10 clk = ~clk;

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_char(input byte_t got, input byte_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_state(input arb_state_e got, input arb_state_e exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  function automatic logic is_periph(input addr_t a);
    return (a == SERIAL_ADDR) || (a == RTC_ADDR) || (a == RTC_ADDR_UP);
  endfunction

  function automatic word_t model_read(input addr_t a);
    if (mem_model.exists(a[31:2]))
    begin
      return mem_model[a[31:2]];
    end
    // untouched words hold the inverted word address
    return ~{a[31:2], 2'b00};
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t wdata, input strb_t wstrb);
    word_t res;
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (wstrb[i])
      begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // raise valid on both sides as asked, then drop each one after its completion pulse
  task automatic run_access(input logic use_ifu, input logic use_lsu, input logic we,
                            input addr_t ifu_addr_v, input addr_t lsu_addr_v,
                            input word_t wdata, input strb_t wstrb,
                            output word_t ifu_data, output word_t lsu_data);
    logic ifu_wait;
    logic lsu_wait;
    logic ifu_now;
    logic lsu_now;
    int   step;
    ifu_data = '0;
    lsu_data = '0;
    ifu_wait = use_ifu;
    lsu_wait = use_lsu;
    step = 0;
    @(posedge clk);
    if (use_ifu)
    begin
      ifu_arvalid <= 1'b1;
      ifu_araddr  <= ifu_addr_v;
    end
    if (use_lsu)
    begin
      lsu_valid <= 1'b1;
      lsu_we    <= we;
      lsu_addr  <= lsu_addr_v;
      lsu_wdata <= wdata;
      lsu_wstrb <= wstrb;
    end
    while (ifu_wait || lsu_wait)
    begin
      @(negedge clk);
      ifu_now = ifu_rvalid;
      lsu_now = lsu_rvalid | lsu_wready;
      // grant is registered, so the busy state shows one cycle after valid
      if (use_ifu && use_lsu && (step == 1))
      begin
        check_state(dut.state, LSU_BUSY, "grant on paired request");
      end
      if (ifu_now)
      begin
        ifu_data = ifu_rdata;
        if (lsu_wait)
        begin
          errors++;
          $display("fetch completed before the pending load/store at time %0t", $time);
        end
      end
      if (lsu_now)
      begin
        lsu_data = lsu_rdata;
        if (lsu_wready !== we)
        begin
          errors++;
          $display("load/store completed with the wrong strobe at time %0t", $time);
        end
      end
      @(posedge clk);
      if (ifu_now)
      begin
        ifu_arvalid <= 1'b0;
        ifu_wait = 1'b0;
      end
      if (lsu_now)
      begin
        lsu_valid <= 1'b0;
        lsu_wait = 1'b0;
      end
      step++;
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst && serial_valid)
    begin
      serial_count++;
      last_char = serial_char;
    end
  end

  // memory slave: random ready stall, then a response 1 to 4 cycles after acceptance
  always @(posedge clk)
  begin
    rsp_next = '0;
    if (rst)
    begin
      mem_busy = 1'b0;
      stall_left = $urandom % 4;
    end
    else if (mem_busy)
    begin
      if (lat_left <= 1)
      begin
        if (mem_cur.we)
        begin
          mem_model[mem_cur.addr[31:2]] = merge_bytes(model_read(mem_cur.addr),
                                                      mem_cur.wdata, mem_cur.wstrb);
          rsp_next.bvalid = 1'b1;
        end
        else
        begin
          rsp_next.rvalid = 1'b1;
          rsp_next.rdata  = model_read(mem_cur.addr);
        end
        mem_busy = 1'b0;
        stall_left = $urandom % 4;
      end
      else
      begin
        lat_left--;
      end
    end
    else if (mem_req.valid && mem_rsp.ready)
    begin
      mem_cur = '{addr: mem_req.addr, wdata: mem_req.wdata, wstrb: mem_req.wstrb,
                  we: mem_req.we};
      mem_reqs++;
      mem_busy = 1'b1;
      lat_left = 1 + ($urandom % 4);
    end
    else if (mem_req.valid)
    begin
      if (stall_left == 0)
      begin
        rsp_next.ready = 1'b1;
      end
      else
      begin
        stall_left--;
      end
    end
    mem_rsp <= rsp_next;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial
  begin
    int    seed;
    int    n_lines;
    int    kind;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    word_t exp;
    word_t got;
    word_t got_ifu;
    word_t got_lsu;
    word_t last_rtc;
    int    exp_mem;
    int    exp_serial;
    seed = $urandom(32'hf172);
    rst         <= 1'b1;
    ifu_arvalid <= 1'b0;
    ifu_araddr  <= '0;
    lsu_valid   <= 1'b0;
    lsu_we      <= 1'b0;
    lsu_addr    <= '0;
    lsu_wdata   <= '0;
    lsu_wstrb   <= '0;
    mem_rsp     <= '0;
    for (int i = 0; i < $size(vec); i++)
    begin
      vec[i] = '0;
    end
    $readmemh("bus_input.txt", vec);
    n_lines = 0;
    while ((5 * n_lines < $size(vec)) && (vec[5 * n_lines] != '0))
    begin
      n_lines++;
    end
    cycle_limit = 40 * n_lines + 100;
    last_rtc = '0;
    exp_mem = 0;
    exp_serial = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int ln = 0; ln < n_lines; ln++)
    begin
      kind  = vec[5 * ln];
      addr  = vec[5 * ln + 1];
      wdata = vec[5 * ln + 2];
      wstrb = vec[5 * ln + 3][3:0];
      exp   = vec[5 * ln + 4];
      run_access((kind == 1) || (kind == 4), kind != 1, kind == 3,
                 (kind == 4) ? wdata : addr, addr, wdata, wstrb, got_ifu, got_lsu);
      if (!is_periph(addr))
      begin
        exp_mem++;
      end
      if ((kind == 4) && !is_periph(wdata))
      begin
        exp_mem++;
      end
      if (kind == 3)
      begin
        if (addr == SERIAL_ADDR)
        begin
          exp_serial++;
          check_char(last_char, exp[7:0], "serial char");
        end
      end
      else
      begin
        got = (kind == 1) ? got_ifu : got_lsu;
        if (addr == RTC_ADDR)
        begin
          checks++;
          if (got <= last_rtc)
          begin
            errors++;
            $display("Error at time %0t: timer read %h is not above %h", $time, got, last_rtc);
          end
          last_rtc = got;
        end
        else
        begin
          check_word(got, exp, "read data");
        end
        if (kind == 4)
        begin
          check_word(got_ifu, model_read(wdata), "paired fetch data");
        end
      end
      @(negedge clk);
      check_state(dut.state, IDLE, "state after transaction");
      check_word(word_t'(mem_reqs), word_t'(exp_mem), "memory request count");
      check_word(word_t'(serial_count), word_t'(exp_serial), "serial pulse count");
    end
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut.u_assertions.fail_count);
    if ((errors == 0) && (dut.u_assertions.fail_count == 0))
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
